// ==== riscv_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// RV32 vector instruction encoding, OPMVV layout only
// Only the mask-logical funct6 group is listed here
////////////////////////////////////////////////////////////////////////////

package riscv_pkg;

    // OPMVV word, fields from MSB to LSB
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } riscv_opmvv_t;

    // Major opcode of OP-V
    localparam logic [6:0] RISCV_OP_V = 7'b1010111;

    // funct3 for the OPMVV category
    localparam logic [2:0] RISCV_F3_OPMVV = 3'b010;

    // Mask-register logical group, 011xxx
    typedef enum logic [5:0] {
        RISCV_V_VMANDN = 6'b011000,
        RISCV_V_VMAND  = 6'b011001,
        RISCV_V_VMOR   = 6'b011010,
        RISCV_V_VMXOR  = 6'b011011,
        RISCV_V_VMORN  = 6'b011100,
        RISCV_V_VMNAND = 6'b011101,
        RISCV_V_VMNOR  = 6'b011110,
        RISCV_V_VMXNOR = 6'b011111
    } riscv_v_mask_funct6_e;

endpackage : riscv_pkg

// ==== riscv_v_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Vector register geometry for the mask unit
// A mask register holds one bit per element, element 0 in bit 0
////////////////////////////////////////////////////////////////////////////

package riscv_v_pkg;

    // Mask bits per vector register
    localparam int RISCV_V_NUM_ELEMENTS_REG = 64;

    // One full mask register
    typedef logic [RISCV_V_NUM_ELEMENTS_REG-1:0] riscv_v_mask_reg_t;

    // Index into the 32-entry register file
    typedef logic [4:0] riscv_v_reg_addr_t;

endpackage : riscv_v_pkg

// ==== riscv_v_mask_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Internal buses of the mask unit, not meant for the top-level boundary
// Control bus signals are levels, valid for one cycle per instruction
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

// Decoded controls and operands from issue to the lanes and writeback
interface riscv_v_mask_ctrl_if
import riscv_v_pkg::*;
();

    logic              valid;
    logic              is_mask;
    logic              is_and;
    logic              is_or;
    logic              is_xor;
    logic              is_negate_srca;
    logic              is_negate_result;
    riscv_v_mask_reg_t srca;
    riscv_v_mask_reg_t srcb;
    riscv_v_reg_addr_t vd;

    modport issue (
        output valid, is_mask, is_and, is_or, is_xor,
        output is_negate_srca, is_negate_result, srca, srcb, vd
    );

    // Lanes see only the gate controls and the operands
    modport lane (
        input is_mask, is_and, is_or, is_xor,
        input is_negate_srca, is_negate_result, srca, srcb
    );

    modport wb (
        input valid, vd
    );

endinterface : riscv_v_mask_ctrl_if

// Register file access, two operand reads and one write
interface riscv_v_mask_rf_if
import riscv_v_pkg::*;
();

    riscv_v_reg_addr_t rs1_addr;
    riscv_v_mask_reg_t rs1_data;
    riscv_v_reg_addr_t rs2_addr;
    riscv_v_mask_reg_t rs2_data;
    logic              we;
    riscv_v_reg_addr_t waddr;
    riscv_v_mask_reg_t wdata;

    modport rd (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
    modport wr (output we, waddr, wdata);
    modport rf (
        input  rs1_addr, rs2_addr, we, waddr, wdata,
        output rs1_data, rs2_data
    );

endinterface : riscv_v_mask_rf_if

// ==== riscv_v_mask_regfile.sv ====
////////////////////////////////////////////////////////////////////////////
// 32 mask registers, cleared by synchronous reset
// Operand reads forward a same-cycle write, the debug read does not
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module riscv_v_mask_regfile
import riscv_v_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    riscv_v_mask_rf_if.rf     rf,
    input  riscv_v_reg_addr_t dbg_addr,
    output riscv_v_mask_reg_t dbg_data
);

    localparam int NUM_REGS = 32;

    riscv_v_mask_reg_t regs [NUM_REGS];

    logic fwd_rs1;
    logic fwd_rs2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // Forward the pending write so back-to-back dependents see it
    assign fwd_rs1 = rf.we && (rf.waddr == rf.rs1_addr);
    assign fwd_rs2 = rf.we && (rf.waddr == rf.rs2_addr);

    assign rf.rs1_data = fwd_rs1 ? rf.wdata : regs[rf.rs1_addr];
    assign rf.rs2_data = fwd_rs2 ? rf.wdata : regs[rf.rs2_addr];

    // Debug port shows stored contents only
    assign dbg_data = regs[dbg_addr];

endmodule : riscv_v_mask_regfile

// ==== riscv_v_mask_issue.sv ====
////////////////////////////////////////////////////////////////////////////
// Decodes one OPMVV mask-logical instruction per cycle, no stall
// vm is ignored, anything outside the mask group is flagged illegal
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module riscv_v_mask_issue
import riscv_pkg::*, riscv_v_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  riscv_opmvv_t         instr,
    output logic                 illegal,
    riscv_v_mask_rf_if.rd        rf,
    riscv_v_mask_ctrl_if.issue   ctrl
);

    localparam int SLICE_W = RISCV_V_NUM_ELEMENTS_REG / NUM_LANES;

    logic legal_f6;
    logic legal;
    logic accept;
    logic dec_and;
    logic dec_or;
    logic dec_xor;
    logic dec_neg_a;
    logic dec_neg_res;

    // Operands are looked up straight from the incoming word
    assign rf.rs1_addr = instr.vs1;
    assign rf.rs2_addr = instr.vs2;

    always_comb begin
        legal_f6    = 1'b1;
        dec_and     = 1'b0;
        dec_or      = 1'b0;
        dec_xor     = 1'b0;
        dec_neg_a   = 1'b0;
        dec_neg_res = 1'b0;
        case (instr.funct6)
            RISCV_V_VMAND:  dec_and = 1'b1;
            RISCV_V_VMNAND: begin
                dec_and     = 1'b1;
                dec_neg_res = 1'b1;
            end
            // vs2 & ~vs1
            RISCV_V_VMANDN: begin
                dec_and   = 1'b1;
                dec_neg_a = 1'b1;
            end
            RISCV_V_VMOR:   dec_or = 1'b1;
            RISCV_V_VMNOR: begin
                dec_or      = 1'b1;
                dec_neg_res = 1'b1;
            end
            RISCV_V_VMORN: begin
                dec_or    = 1'b1;
                dec_neg_a = 1'b1;
            end
            RISCV_V_VMXOR:  dec_xor = 1'b1;
            RISCV_V_VMXNOR: begin
                dec_xor     = 1'b1;
                dec_neg_res = 1'b1;
            end
            default:        legal_f6 = 1'b0;
        endcase
    end

    assign legal  = (instr.opcode == RISCV_OP_V) && (instr.funct3 == RISCV_F3_OPMVV)
                 && legal_f6;
    assign accept = instr_valid && legal;

    // Gate controls, all zero when the bus is idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.valid            <= 1'b0;
            ctrl.is_mask          <= 1'b0;
            ctrl.is_and           <= 1'b0;
            ctrl.is_or            <= 1'b0;
            ctrl.is_xor           <= 1'b0;
            ctrl.is_negate_srca   <= 1'b0;
            ctrl.is_negate_result <= 1'b0;
            illegal               <= 1'b0;
        end else begin
            ctrl.valid            <= accept;
            ctrl.is_mask          <= accept;
            ctrl.is_and           <= accept && dec_and;
            ctrl.is_or            <= accept && dec_or;
            ctrl.is_xor           <= accept && dec_xor;
            ctrl.is_negate_srca   <= accept && dec_neg_a;
            ctrl.is_negate_result <= accept && dec_neg_res;
            illegal               <= instr_valid && !legal;
        end
    end

    // Operand flops grouped per lane slice, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl.vd <= instr.vd;
            for (int l = 0; l < NUM_LANES; l++) begin
                ctrl.srca[l*SLICE_W +: SLICE_W] <= rf.rs1_data[l*SLICE_W +: SLICE_W];
                ctrl.srcb[l*SLICE_W +: SLICE_W] <= rf.rs2_data[l*SLICE_W +: SLICE_W];
            end
        end
    end

    // Exactly one logic path per issued instruction, all lanes rely on it
    a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.valid |-> $onehot({ctrl.is_and, ctrl.is_or, ctrl.is_xor}));

endmodule : riscv_v_mask_issue

// ==== riscv_v_mask_alu.sv ====
////////////////////////////////////////////////////////////////////////////
// One lane of the mask ALU, purely combinational
// Works on bits LANE*SLICE_W and up of the operands on the control bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module riscv_v_mask_alu
import riscv_v_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int LANE      = 0
)
(
    riscv_v_mask_ctrl_if.lane                               ctrl,
    output logic [RISCV_V_NUM_ELEMENTS_REG/NUM_LANES-1:0]   slice
);

    localparam int SLICE_W = RISCV_V_NUM_ELEMENTS_REG / NUM_LANES;

    logic [SLICE_W-1:0] srca;
    logic [SLICE_W-1:0] srcb;
    logic [SLICE_W-1:0] srca_sel;
    logic [SLICE_W-1:0] and_res;
    logic [SLICE_W-1:0] or_res;
    logic [SLICE_W-1:0] xor_res;
    logic [SLICE_W-1:0] merged;
    logic [SLICE_W-1:0] res_sel;

    assign srca = ctrl.srca[LANE*SLICE_W +: SLICE_W];
    assign srcb = ctrl.srcb[LANE*SLICE_W +: SLICE_W];

    // Optional inversion of srca for the andn/orn forms
    assign srca_sel = srca ^ {SLICE_W{ctrl.is_negate_srca}};

    // Each path is forced to zero unless selected
    assign and_res = (srca_sel & {SLICE_W{ctrl.is_and}}) & srcb;
    assign or_res  = (srca_sel & {SLICE_W{ctrl.is_or}})  | (srcb & {SLICE_W{ctrl.is_or}});
    assign xor_res = (srca_sel & {SLICE_W{ctrl.is_xor}}) ^ (srcb & {SLICE_W{ctrl.is_xor}});

    assign merged  = and_res | or_res | xor_res;
    assign res_sel = merged ^ {SLICE_W{ctrl.is_negate_result}};

    // Idle bus gives zero
    assign slice = res_sel & {SLICE_W{ctrl.is_mask}};

endmodule : riscv_v_mask_alu

// ==== riscv_v_mask_writeback.sv ====
////////////////////////////////////////////////////////////////////////////
// Joins the lane slices and owns the register-file write port
// External loads must never coincide with a completing instruction
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module riscv_v_mask_writeback
import riscv_v_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    riscv_v_mask_ctrl_if.wb      ctrl,
    input  logic [NUM_LANES-1:0][RISCV_V_NUM_ELEMENTS_REG/NUM_LANES-1:0] slices,
    input  logic                 load_valid,
    input  riscv_v_reg_addr_t    load_addr,
    input  riscv_v_mask_reg_t    load_data,
    riscv_v_mask_rf_if.wr        rf,
    output logic                 done,
    output riscv_v_reg_addr_t    done_vd,
    output riscv_v_mask_reg_t    result
);

    riscv_v_mask_reg_t word;

    // Lane 0 holds the low slice
    assign word = slices;

    // Instruction results take the port, loads use it otherwise
    assign rf.we    = ctrl.valid || load_valid;
    assign rf.waddr = ctrl.valid ? ctrl.vd : load_addr;
    assign rf.wdata = ctrl.valid ? word : load_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= ctrl.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.valid) begin
            done_vd <= ctrl.vd;
            result  <= word;
        end
    end

    // A load would otherwise be dropped silently
    a_no_load_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_valid && ctrl.valid));

endmodule : riscv_v_mask_writeback

// ==== riscv_v_mask_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Mask-logical vector unit, one instruction per clock, 2-cycle latency
// NUM_LANES must divide the mask element count, no back-pressure
// Loads and instructions are not allowed to overlap
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module riscv_v_mask_unit
import riscv_pkg::*, riscv_v_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  riscv_opmvv_t      instr,
    input  logic              load_valid,
    input  riscv_v_reg_addr_t load_addr,
    input  riscv_v_mask_reg_t load_data,
    input  riscv_v_reg_addr_t dbg_addr,
    output riscv_v_mask_reg_t dbg_data,
    output logic              done,
    output riscv_v_reg_addr_t done_vd,
    output riscv_v_mask_reg_t result,
    output logic              illegal
);

    localparam int SLICE_W = RISCV_V_NUM_ELEMENTS_REG / NUM_LANES;

    if ((RISCV_V_NUM_ELEMENTS_REG % NUM_LANES) != 0) begin : g_lane_check
        $error("NUM_LANES must divide RISCV_V_NUM_ELEMENTS_REG");
    end

    riscv_v_mask_ctrl_if ctrl_bus ();
    riscv_v_mask_rf_if   rf_bus ();

    logic [NUM_LANES-1:0][SLICE_W-1:0] lane_slices;

    riscv_v_mask_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rf       (rf_bus.rf),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    riscv_v_mask_issue #(
        .NUM_LANES (NUM_LANES)
    ) u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .illegal     (illegal),
        .rf          (rf_bus.rd),
        .ctrl        (ctrl_bus.issue)
    );

    // Identical lanes, each on its own slice
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        riscv_v_mask_alu #(
            .NUM_LANES (NUM_LANES),
            .LANE      (l)
        ) u_alu (
            .ctrl  (ctrl_bus.lane),
            .slice (lane_slices[l])
        );
    end

    riscv_v_mask_writeback #(
        .NUM_LANES (NUM_LANES)
    ) u_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.wb),
        .slices     (lane_slices),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rf         (rf_bus.wr),
        .done       (done),
        .done_vd    (done_vd),
        .result     (result)
    );

endmodule : riscv_v_mask_unit

// ==== tb_riscv_v_mask_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Random testbench for the mask unit against a sequential register model
// Loads and instructions are kept apart, as the DUT requires
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_riscv_v_mask_unit
import riscv_pkg::*, riscv_v_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int BURST_LEN   = 200;
    // reset, load+read, single ops, burst, illegal, mid-run reset, drain
    localparam int STIM_CYCLES = 3 + 64 + 32 + (BURST_LEN + 35) + 47 + 42 + 2;
    localparam int MARGIN      = 50;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    riscv_opmvv_t      instr;
    logic              load_valid;
    riscv_v_reg_addr_t load_addr;
    riscv_v_mask_reg_t load_data;
    riscv_v_reg_addr_t dbg_addr;
    riscv_v_mask_reg_t dbg_data;
    logic              done;
    riscv_v_reg_addr_t done_vd;
    riscv_v_mask_reg_t result;
    logic              illegal;

    riscv_v_mask_reg_t model_regs [32];
    int                done_cyc_q [$];
    riscv_v_reg_addr_t done_vd_q [$];
    riscv_v_mask_reg_t done_res_q [$];
    int                ill_cyc_q [$];
    int                cyc;
    logic              mon_en;
    logic              exp_done;
    logic              exp_ill;
    string             test_name;
    int                word_errs;
    int                addr_errs;
    int                flag_errs;
    int                other_errs;

    riscv_v_mask_unit #(.NUM_LANES(4)) dut (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data), .done(done), .done_vd(done_vd),
        .result(result), .illegal(illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_word(input string what, input riscv_v_mask_reg_t exp,
                              input riscv_v_mask_reg_t act);
        if (act !== exp) begin
            word_errs++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input riscv_v_reg_addr_t exp,
                              input riscv_v_reg_addr_t act);
        if (act !== exp) begin
            addr_errs++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // Reference result taken from the mask instruction table, a = vs1, b = vs2
    function automatic riscv_v_mask_reg_t mask_op(input logic [5:0] f6,
            input riscv_v_mask_reg_t a, input riscv_v_mask_reg_t b);
        case (f6)
            RISCV_V_VMAND:  return a & b;
            RISCV_V_VMNAND: return ~(a & b);
            RISCV_V_VMANDN: return b & ~a;
            RISCV_V_VMOR:   return a | b;
            RISCV_V_VMNOR:  return ~(a | b);
            RISCV_V_VMORN:  return b | ~a;
            RISCV_V_VMXOR:  return a ^ b;
            default:        return ~(a ^ b);
        endcase
    endfunction

    function automatic riscv_opmvv_t make_instr(input logic [5:0] f6,
            input riscv_v_reg_addr_t vs1, input riscv_v_reg_addr_t vs2,
            input riscv_v_reg_addr_t vd);
        logic [31:0] r;
        r = $urandom;
        return '{funct6: f6, vm: r[0], vs2: vs2, vs1: vs1, funct3: RISCV_F3_OPMVV,
                 vd: vd, opcode: RISCV_OP_V};
    endfunction

    task automatic load_reg(input riscv_v_reg_addr_t addr, input riscv_v_mask_reg_t data);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
        model_regs[addr] = data;
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    // Model applies the instruction as soon as the DUT samples it
    task automatic issue_instr(input riscv_opmvv_t w);
        instr_valid = 1'b1;
        instr       = w;
        if (w.opcode == RISCV_OP_V && w.funct3 == RISCV_F3_OPMVV && w.funct6[5:3] == 3'b011) begin
            model_regs[w.vd] = mask_op(w.funct6, model_regs[w.vs1], model_regs[w.vs2]);
            done_cyc_q.push_back(cyc + 2);
            done_vd_q.push_back(w.vd);
            done_res_q.push_back(model_regs[w.vd]);
        end else begin
            ill_cyc_q.push_back(cyc + 1);
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic read_all();
        for (int i = 0; i < 32; i++) begin
            dbg_addr = riscv_v_reg_addr_t'(i);
            #(CLK_PERIOD / 4);
            check_word($sformatf("v%0d", i), model_regs[i], dbg_data);
            @(negedge clk);
        end
    endtask

    task automatic apply_reset();
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        load_valid  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        check_flag("done after reset", 1'b0, done);
        check_flag("illegal after reset", 1'b0, illegal);
    endtask

    // Outputs only change on rising edges, so look at them on the falling one
    always @(negedge clk) begin
        if (mon_en) begin
            exp_done = (done_cyc_q.size() > 0) && (done_cyc_q[0] == cyc);
            exp_ill  = (ill_cyc_q.size() > 0) && (ill_cyc_q[0] == cyc);
            check_flag("done", exp_done, done);
            check_flag("illegal", exp_ill, illegal);
            if (exp_done) begin
                check_addr("done_vd", done_vd_q.pop_front(), done_vd);
                check_word("result", done_res_q.pop_front(), result);
                void'(done_cyc_q.pop_front());
            end
            if (exp_ill) begin
                void'(ill_cyc_q.pop_front());
            end
        end
    end

    initial begin
        #((STIM_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: run still going after %0d cycles", STIM_CYCLES + MARGIN);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        riscv_opmvv_t w;
        logic [31:0]  r;
        void'($urandom(87450));
        clk = 1'b0;
        instr = '0;
        load_addr = '0;
        load_data = '0;
        dbg_addr = '0;
        cyc = 0;
        mon_en = 1'b0;
        {word_errs, addr_errs, flag_errs, other_errs} = '0;
        test_name = "reset";
        apply_reset();
        mon_en = 1'b1;

        test_name = "load_readback";
        for (int i = 0; i < 32; i++) begin
            load_reg(riscv_v_reg_addr_t'(i), {$urandom, $urandom});
        end
        read_all();

        test_name = "single_ops";
        for (int k = 0; k < 8; k++) begin
            r = $urandom;
            issue_instr(make_instr(6'b011000 + 6'(k), r[4:0], r[9:5], r[14:10]));
            repeat (3) @(negedge clk);
        end

        // Few registers, so most instructions depend on the one before
        test_name = "burst";
        for (int k = 0; k < BURST_LEN; k++) begin
            r = $urandom;
            issue_instr(make_instr({3'b011, r[2:0]}, {3'b000, r[4:3]}, {3'b000, r[6:5]},
                                   {3'b000, r[8:7]}));
        end
        repeat (3) @(negedge clk);
        read_all();

        test_name = "illegal";
        for (int k = 0; k < 4; k++) begin
            r = $urandom;
            w = make_instr({3'b011, r[2:0]}, r[7:3], r[12:8], r[17:13]);
            w.opcode = (r[24:18] == RISCV_OP_V) ? 7'b0110011 : r[24:18];
            issue_instr(w);
            w = make_instr({3'b011, r[2:0]}, r[7:3], r[12:8], r[17:13]);
            w.funct3 = (r[27:25] == RISCV_F3_OPMVV) ? 3'b000 : r[27:25];
            issue_instr(w);
            w = make_instr({3'b011, r[2:0]}, r[7:3], r[12:8], r[17:13]);
            w.funct6 = {(r[30:28] == 3'b011) ? 3'b100 : r[30:28], r[2:0]};
            issue_instr(w);
        end
        repeat (3) @(negedge clk);
        read_all();

        test_name = "mid_reset";
        for (int k = 0; k < 4; k++) begin
            r = $urandom;
            issue_instr(make_instr({3'b011, r[2:0]}, r[7:3], r[12:8], r[17:13]));
        end
        repeat (3) @(negedge clk);
        apply_reset();
        read_all();

        repeat (2) @(negedge clk);
        if (done_cyc_q.size() != 0 || ill_cyc_q.size() != 0) begin
            other_errs++;
            $display("Some expected completions or illegal pulses never showed up");
        end
        $display("Errors: word %0d, address %0d, flag %0d, other %0d",
                 word_errs, addr_errs, flag_errs, other_errs);
        if (word_errs + addr_errs + flag_errs + other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_riscv_v_mask_unit

// ==== filelist.f ====
riscv_pkg.sv
riscv_v_pkg.sv
riscv_v_mask_if.sv
riscv_v_mask_regfile.sv
riscv_v_mask_issue.sv
riscv_v_mask_alu.sv
riscv_v_mask_writeback.sv
riscv_v_mask_unit.sv
tb_riscv_v_mask_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mask unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_riscv_v_mask_unit -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
